// File: compile.f
+incdir+source
source/synapse_pkg.sv
source/weight_write_router.sv
source/weight_bank.sv
source/fanout_controller.sv
source/spike_serializer.sv
source/synapse_array_top.sv
dv/synapse_array_tb.sv

// File: dv/synapse_array_tb.sv
`default_nettype none

`include "synapse_cfg.svh"

module synapse_array_tb
    import synapse_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h919d4298;
    localparam int NB = `SYN_NUM_BANKS;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_BATCH,
        OP_SPIKE
    } op_kind_t;

    // One table row; unused fields stay zero
    typedef struct packed {
        op_kind_t                       kind;
        axon_id_t                       axon;
        neuron_id_t                     neuron;
        group_id_t                      group;
        synapse_weight_t                weight;
        synapse_weight_t [NB-1:0]       batch;
        logic                           with_single;
        logic                           stall;
    } op_t;

    logic            clk;
    logic            rst_n;
    logic            spike_in_valid;
    axon_id_t        spike_in_axon;
    logic            spike_in_ready;
    logic            weight_we;
    axon_id_t        weight_axon;
    neuron_id_t      weight_neuron;
    synapse_weight_t weight_data;
    logic            batch_we;
    axon_id_t        batch_axon;
    group_id_t       batch_group;
    synapse_weight_t batch_data [NB];
    logic            enable;
    logic            spike_out_valid;
    spike_event_t    spike_out;
    logic            busy;
    logic [31:0]     spike_count;

    op_t             ops [$];
    synapse_weight_t model [`SYN_NUM_AXONS][`SYN_NUM_NEURONS];
    int              total_events;
    bit              table_ready;

    synapse_array_top synapse_array_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .spike_in_valid_i  (spike_in_valid),
        .spike_in_axon_i   (spike_in_axon),
        .spike_in_ready_o  (spike_in_ready),
        .weight_we_i       (weight_we),
        .weight_axon_i     (weight_axon),
        .weight_neuron_i   (weight_neuron),
        .weight_data_i     (weight_data),
        .batch_we_i        (batch_we),
        .batch_axon_i      (batch_axon),
        .batch_group_i     (batch_group),
        .batch_data_i      (batch_data),
        .enable_i          (enable),
        .spike_out_valid_o (spike_out_valid),
        .spike_out_o       (spike_out),
        .busy_o            (busy),
        .spike_count_o     (spike_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ================================================
    // Checking helpers
    // ================================================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic synapse_weight_t make_weight(input logic exc, input int mag);
        synapse_weight_t w;
        w.exc = exc;
        w.mag = weight_mag_t'(mag);
        return w;
    endfunction

    // About one weight in four comes out zero
    function automatic synapse_weight_t random_weight();
        synapse_weight_t w;
        w.exc = 1'($urandom_range(0, 1));
        if ($urandom_range(0, 3) == 0) begin
            w.mag = '0;
        end else begin
            w.mag = weight_mag_t'($urandom_range(1, 255));
        end
        return w;
    endfunction

    // ================================================
    // Stimulus table
    // ================================================
    function automatic void write_entry(input int axon, input int neuron,
                                        input synapse_weight_t w);
        op_t op;
        op        = '0;
        op.kind   = OP_WRITE;
        op.axon   = axon_id_t'(axon);
        op.neuron = neuron_id_t'(neuron);
        op.weight = w;
        ops.push_back(op);
    endfunction

    function automatic void batch_entry(input int axon, input int group, input bit with_single,
                                        input int neuron, input synapse_weight_t w);
        op_t op;
        op             = '0;
        op.kind        = OP_BATCH;
        op.axon        = axon_id_t'(axon);
        op.group       = group_id_t'(group);
        op.with_single = with_single;
        op.neuron      = neuron_id_t'(neuron);
        op.weight      = w;
        for (int k = 0; k < NB; k++) begin
            op.batch[k] = random_weight();
        end
        ops.push_back(op);
    endfunction

    function automatic void spike_entry(input int axon, input bit stall);
        op_t op;
        op       = '0;
        op.kind  = OP_SPIKE;
        op.axon  = axon_id_t'(axon);
        op.stall = stall;
        ops.push_back(op);
    endfunction

    task automatic build_table();
        // Fixed weights on axon 3, two of them inhibitory
        write_entry(3, 0, make_weight(1, 10));
        write_entry(3, 5, make_weight(0, 200));
        write_entry(3, 6, make_weight(1, 1));
        write_entry(3, 13, make_weight(0, 77));
        write_entry(3, 31, make_weight(1, 255));
        write_entry(3, 20, make_weight(1, 40));
        write_entry(3, 20, make_weight(1, 0));
        spike_entry(3, 0);
        // Neuron 9 sits in group 2, neuron 2 shares bank 2 with group 4
        batch_entry(5, 2, 1, 9, make_weight(0, 99));
        batch_entry(5, 7, 0, 0, '0);
        batch_entry(5, 4, 1, 2, make_weight(1, 33));
        spike_entry(5, 0);
        // Axon never written
        spike_entry(9, 0);
        for (int i = 0; i < 6; i++) begin
            write_entry(12, $urandom_range(0, 31), random_weight());
            batch_entry(12, $urandom_range(0, 7), i % 2, $urandom_range(0, 31), random_weight());
        end
        spike_entry(12, 1);
        spike_entry(3, 1);
        spike_entry(5, 0);
    endtask

    // ================================================
    // Drivers
    // ================================================
    task automatic single_write(input op_t op);
        weight_we     = 1'b1;
        weight_axon   = op.axon;
        weight_neuron = op.neuron;
        weight_data   = op.weight;
        @(negedge clk);
        weight_we = 1'b0;
        model[op.axon][op.neuron] = op.weight;
    endtask

    task automatic group_write(input op_t op);
        int base;
        base        = op.group * NB;
        batch_we    = 1'b1;
        batch_axon  = op.axon;
        batch_group = op.group;
        for (int k = 0; k < NB; k++) begin
            batch_data[k] = op.batch[k];
        end
        if (op.with_single) begin
            weight_we     = 1'b1;
            weight_axon   = op.axon;
            weight_neuron = op.neuron;
            weight_data   = op.weight;
        end
        @(negedge clk);
        batch_we  = 1'b0;
        weight_we = 1'b0;
        // The single write owns its bank for this cycle
        for (int k = 0; k < NB; k++) begin
            if (!(op.with_single && (op.neuron % NB) == k)) begin
                model[op.axon][base + k] = op.batch[k];
            end
        end
        if (op.with_single) begin
            model[op.axon][op.neuron] = op.weight;
        end
    endtask

    task automatic process_spike(input op_t op);
        spike_event_t exp_q [$];
        spike_event_t got_q [$];
        spike_event_t ev;
        int           gap;
        int           cycle;
        for (int n = 0; n < `SYN_NUM_NEURONS; n++) begin
            if (model[op.axon][n].mag != '0) begin
                ev.neuron = neuron_id_t'(n);
                ev.weight = model[op.axon][n];
                exp_q.push_back(ev);
            end
        end
        gap = op.stall ? $urandom_range(3, 12) : 0;
        check_value("ready before spike", spike_in_ready, 1);
        spike_in_valid = 1'b1;
        spike_in_axon  = op.axon;
        enable         = (gap == 0);
        cycle          = 0;
        do begin
            @(negedge clk);
            cycle++;
            // Second offer lands while busy and must be dropped
            if (cycle == 1) begin
                check_value("busy after accept", busy, 1);
                check_value("ready after accept", spike_in_ready, 0);
                spike_in_axon = op.axon + 1'b1;
            end else if (cycle == 2) begin
                spike_in_valid = 1'b0;
            end
            if (spike_out_valid) begin
                check_value("event while disabled", cycle <= gap, 0);
                got_q.push_back(spike_out);
            end
            if (cycle == gap) begin
                enable = 1'b1;
            end
        end while (busy || cycle < 2);
        check_value("event count", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value("event neuron", got_q[i].neuron, exp_q[i].neuron);
            check_value("event magnitude", got_q[i].weight.mag, exp_q[i].weight.mag);
            check_value("event excitatory flag", got_q[i].weight.exc, exp_q[i].weight.exc);
        end
        total_events += exp_q.size();
        check_value("spike_count_o", spike_count, total_events);
    endtask

    // ================================================
    // Main sequence, invariant and watchdog
    // ================================================
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("ready while busy", busy && spike_in_ready, 0);
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n          = 1'b0;
        spike_in_valid = 1'b0;
        spike_in_axon  = '0;
        weight_we      = 1'b0;
        weight_axon    = '0;
        weight_neuron  = '0;
        weight_data    = '0;
        batch_we       = 1'b0;
        batch_axon     = '0;
        batch_group    = '0;
        batch_data     = '{default: '0};
        enable         = 1'b1;
        total_events   = 0;
        model          = '{default: '{default: '0}};
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("valid after reset", spike_out_valid, 0);
        check_value("busy after reset", busy, 0);
        check_value("ready after reset", spike_in_ready, 1);
        check_value("count after reset", spike_count, 0);
        foreach (ops[i]) begin
            case (ops[i].kind)
                OP_WRITE: single_write(ops[i]);
                OP_BATCH: group_write(ops[i]);
                default:  process_spike(ops[i]);
            endcase
        end
        @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (ops.size() * (`SYN_NUM_NEURONS * 2 + 20) + 10) @(posedge clk);
        $display("Simulation failed");
        $fatal(1, "watchdog expired before all table entries were applied");
    end

endmodule

`default_nettype wire

// File: source/fanout_controller.sv
`default_nettype none

`include "synapse_cfg.svh"

module fanout_controller
    import synapse_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      enable_i,

    // Incoming spike
    input  wire logic      spike_in_valid_i,
    input  wire axon_id_t  spike_in_axon_i,
    output logic           spike_in_ready_o,

    // Serializer still emitting events
    input  wire logic      out_draining_i,

    // Scan control to banks and serializer
    output logic           fetch_o,
    output logic           deliver_o,
    output axon_id_t       axon_o,
    output group_id_t      group_o,

    output logic           busy_o
);

    scan_state_t state_q;
    group_id_t   group_q;
    axon_id_t    axon_q;
    logic        pending_q;
    logic        accept;
    logic        last_group;
    logic        scan_done;

    // ================================================
    // Spike capture
    // ================================================
    // Also waits for the serializer so that a new scan never overlaps old events
    assign spike_in_ready_o = (state_q == ST_IDLE) && !pending_q && !out_draining_i;
    assign accept           = spike_in_valid_i && spike_in_ready_o;

    assign last_group = (group_q == group_id_t'(`SYN_NUM_GROUPS - 1));
    assign scan_done  = enable_i && (state_q == ST_NEXT) && last_group;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
        end else if (scan_done) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            axon_q <= spike_in_axon_i;
        end
    end

    // ================================================
    // Group scan FSM
    // ================================================
    // Four enabled cycles per group, frozen while enable is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            group_q <= '0;
        end else if (enable_i) begin
            case (state_q)
                ST_IDLE: begin
                    group_q <= '0;
                    if (pending_q) begin
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state_q <= ST_WAIT;
                end
                // Bank read register fills here
                ST_WAIT: begin
                    state_q <= ST_DELIVER;
                end
                ST_DELIVER: begin
                    state_q <= ST_NEXT;
                end
                ST_NEXT: begin
                    if (last_group) begin
                        state_q <= ST_IDLE;
                        group_q <= '0;
                    end else begin
                        state_q <= ST_FETCH;
                        group_q <= group_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Strobes last exactly one cycle even if the FSM is stalled
    assign fetch_o   = enable_i && (state_q == ST_FETCH);
    assign deliver_o = enable_i && (state_q == ST_DELIVER);
    assign axon_o    = axon_q;
    assign group_o   = group_q;

    assign busy_o = (state_q != ST_IDLE) || pending_q || out_draining_i;

endmodule

`default_nettype wire

// File: source/spike_serializer.sv
`default_nettype none

`include "synapse_cfg.svh"

module spike_serializer
    import synapse_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,

    // Group handoff from the controller
    input  wire logic            deliver_i,
    input  wire group_id_t       group_i,
    input  wire synapse_weight_t bank_data_i [`SYN_NUM_BANKS],

    output logic                 spike_out_valid_o,
    output spike_event_t         spike_out_o,
    output logic [31:0]          spike_count_o,
    output logic                 draining_o
);

    synapse_weight_t lat_q [`SYN_NUM_BANKS];
    group_id_t       group_q;
    bank_sel_t       sel_q;
    logic            active_q;
    synapse_weight_t cur;
    logic            emit;

    // ================================================
    // Group latch and bank walk
    // ================================================
    always_ff @(posedge clk) begin
        if (deliver_i) begin
            lat_q   <= bank_data_i;
            group_q <= group_i;
        end
    end

    // A new deliver may land on the last bank of the previous group
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            sel_q    <= '0;
        end else if (deliver_i) begin
            active_q <= 1'b1;
            sel_q    <= '0;
        end else if (active_q) begin
            if (sel_q == bank_sel_t'(`SYN_NUM_BANKS - 1)) begin
                active_q <= 1'b0;
            end
            sel_q <= sel_q + 1'b1;
        end
    end

    assign cur  = lat_q[sel_q];
    // Zero magnitude means no synapse
    assign emit = active_q && (cur.mag != '0);

    // ================================================
    // Event output
    // ================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spike_out_valid_o         <= 1'b0;
            spike_out_o.neuron        <= '0;
            spike_out_o.weight.exc    <= 1'b1;
            spike_out_o.weight.mag    <= '0;
            spike_count_o             <= '0;
        end else begin
            spike_out_valid_o <= emit;
            if (emit) begin
                spike_out_o.neuron <= neuron_id_t'(group_q * `SYN_NUM_BANKS + sel_q);
                spike_out_o.weight <= cur;
                spike_count_o      <= spike_count_o + 32'd1;
            end
        end
    end

    // Covers the output register too, so busy drops after the last pulse
    assign draining_o = active_q || spike_out_valid_o;

endmodule

`default_nettype wire

// File: source/synapse_array_top.sv
`default_nettype none

`include "synapse_cfg.svh"

module synapse_array_top
    import synapse_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,

    // Spike input
    input  wire logic            spike_in_valid_i,
    input  wire axon_id_t        spike_in_axon_i,
    output logic                 spike_in_ready_o,

    // Single weight write
    input  wire logic            weight_we_i,
    input  wire axon_id_t        weight_axon_i,
    input  wire neuron_id_t      weight_neuron_i,
    input  wire synapse_weight_t weight_data_i,

    // Group write
    input  wire logic            batch_we_i,
    input  wire axon_id_t        batch_axon_i,
    input  wire group_id_t       batch_group_i,
    input  wire synapse_weight_t batch_data_i [`SYN_NUM_BANKS],

    input  wire logic            enable_i,

    // Event output and status
    output logic                 spike_out_valid_o,
    output spike_event_t         spike_out_o,
    output logic                 busy_o,
    output logic [31:0]          spike_count_o
);

    bank_write_t     bank_wr [`SYN_NUM_BANKS];
    synapse_weight_t bank_rd [`SYN_NUM_BANKS];

    logic      fetch;
    logic      deliver;
    axon_id_t  scan_axon;
    group_id_t scan_group;
    logic      out_draining;

    // ================================================
    // Write path
    // ================================================
    weight_write_router weight_write_router_inst (
        .weight_we_i     (weight_we_i),
        .weight_axon_i   (weight_axon_i),
        .weight_neuron_i (weight_neuron_i),
        .weight_data_i   (weight_data_i),
        .batch_we_i      (batch_we_i),
        .batch_axon_i    (batch_axon_i),
        .batch_group_i   (batch_group_i),
        .batch_data_i    (batch_data_i),
        .bank_wr_o       (bank_wr)
    );

    // ================================================
    // Weight banks
    // ================================================
    for (genvar b = 0; b < `SYN_NUM_BANKS; b++) begin : g_bank
        weight_bank weight_bank_inst (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr_i          (bank_wr[b]),
            .fetch_i       (fetch),
            .fetch_axon_i  (scan_axon),
            .fetch_group_i (scan_group),
            .rd_data_o     (bank_rd[b])
        );
    end

    // ================================================
    // Scan control and event output
    // ================================================
    fanout_controller fanout_controller_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .enable_i         (enable_i),
        .spike_in_valid_i (spike_in_valid_i),
        .spike_in_axon_i  (spike_in_axon_i),
        .spike_in_ready_o (spike_in_ready_o),
        .out_draining_i   (out_draining),
        .fetch_o          (fetch),
        .deliver_o        (deliver),
        .axon_o           (scan_axon),
        .group_o          (scan_group),
        .busy_o           (busy_o)
    );

    spike_serializer spike_serializer_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .deliver_i         (deliver),
        .group_i           (scan_group),
        .bank_data_i       (bank_rd),
        .spike_out_valid_o (spike_out_valid_o),
        .spike_out_o       (spike_out_o),
        .spike_count_o     (spike_count_o),
        .draining_o        (out_draining)
    );

endmodule

`default_nettype wire

// File: source/synapse_cfg.svh
`ifndef SYNAPSE_CFG_SVH
`define SYNAPSE_CFG_SVH

// ================================================
// Array dimensions
// ================================================
`define SYN_NUM_AXONS       16
`define SYN_NUM_NEURONS     32
`define SYN_WEIGHT_WIDTH    8

// Neuron n sits in bank n % banks, row n / banks
`define SYN_NUM_BANKS       4
`define SYN_NUM_GROUPS      (`SYN_NUM_NEURONS / `SYN_NUM_BANKS)

// ================================================
// Derived widths
// ================================================
`define SYN_AXON_W          $clog2(`SYN_NUM_AXONS)
`define SYN_NEURON_W        $clog2(`SYN_NUM_NEURONS)
`define SYN_GROUP_W         $clog2(`SYN_NUM_GROUPS)

// One row per axon and group in every bank
`define SYN_BANK_DEPTH      (`SYN_NUM_AXONS * `SYN_NUM_GROUPS)
`define SYN_BANK_ADDR_W     $clog2(`SYN_BANK_DEPTH)
`define SYN_BANK_SEL_W      $clog2(`SYN_NUM_BANKS)

`endif

// File: source/synapse_pkg.sv
`default_nettype none

`include "synapse_cfg.svh"

package synapse_pkg;

    // ================================================
    // Index and value widths
    // ================================================
    typedef logic [`SYN_AXON_W-1:0]       axon_id_t;
    typedef logic [`SYN_NEURON_W-1:0]     neuron_id_t;
    typedef logic [`SYN_GROUP_W-1:0]      group_id_t;
    typedef logic [`SYN_BANK_SEL_W-1:0]   bank_sel_t;
    typedef logic [`SYN_BANK_ADDR_W-1:0]  bank_addr_t;
    typedef logic [`SYN_WEIGHT_WIDTH-1:0] weight_mag_t;

    // ================================================
    // Composite types
    // ================================================
    // Sign kept as a separate flag, 1 means excitatory
    typedef struct packed {
        logic        exc;
        weight_mag_t mag;
    } synapse_weight_t;

    // Write command for a single bank
    typedef struct packed {
        logic            we;
        bank_addr_t      addr;
        synapse_weight_t data;
    } bank_write_t;

    // Output spike payload
    typedef struct packed {
        neuron_id_t      neuron;
        synapse_weight_t weight;
    } spike_event_t;

    // Per-group scan sequence of the controller
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WAIT,
        ST_DELIVER,
        ST_NEXT
    } scan_state_t;

endpackage

`default_nettype wire

// File: source/weight_bank.sv
`default_nettype none

`include "synapse_cfg.svh"

module weight_bank
    import synapse_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,

    input  wire bank_write_t wr_i,

    // Read request from the scan controller
    input  wire logic        fetch_i,
    input  wire axon_id_t    fetch_axon_i,
    input  wire group_id_t   fetch_group_i,

    output synapse_weight_t  rd_data_o
);

    // ================================================
    // Weight storage
    // ================================================
    // Starts out all zero so unwritten synapses stay silent
    synapse_weight_t mem_q [`SYN_BANK_DEPTH] = '{default: '0};

    bank_addr_t rd_addr;

    assign rd_addr = bank_addr_t'(fetch_axon_i * `SYN_NUM_GROUPS + fetch_group_i);

    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            mem_q[wr_i.addr] <= wr_i.data;
        end
    end

    // ================================================
    // Registered read
    // ================================================
    // Held until the next fetch, so a stalled scan keeps its data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else if (fetch_i) begin
            rd_data_o <= mem_q[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/weight_write_router.sv
`default_nettype none

`include "synapse_cfg.svh"

module weight_write_router
    import synapse_pkg::*;
(
    // Single weight write
    input  wire logic            weight_we_i,
    input  wire axon_id_t        weight_axon_i,
    input  wire neuron_id_t      weight_neuron_i,
    input  wire synapse_weight_t weight_data_i,

    // Whole-group write, one entry per bank
    input  wire logic            batch_we_i,
    input  wire axon_id_t        batch_axon_i,
    input  wire group_id_t       batch_group_i,
    input  wire synapse_weight_t batch_data_i [`SYN_NUM_BANKS],

    output bank_write_t          bank_wr_o [`SYN_NUM_BANKS]
);

    bank_sel_t  single_bank;
    group_id_t  single_row;
    bank_addr_t single_addr;
    bank_addr_t batch_addr;

    // Split the neuron index into bank and row within the bank
    assign single_bank = bank_sel_t'(weight_neuron_i % `SYN_NUM_BANKS);
    assign single_row  = group_id_t'(weight_neuron_i / `SYN_NUM_BANKS);

    // Row address inside a bank is axon-major
    assign single_addr = bank_addr_t'(weight_axon_i * `SYN_NUM_GROUPS + single_row);

    // A group write hits the same row in every bank
    assign batch_addr  = bank_addr_t'(batch_axon_i * `SYN_NUM_GROUPS + batch_group_i);

    // Single write takes the bank it targets, batch fills the rest
    always_comb begin
        for (int b = 0; b < `SYN_NUM_BANKS; b++) begin
            bank_wr_o[b] = '0;
            if (weight_we_i && (single_bank == bank_sel_t'(b))) begin
                bank_wr_o[b].we   = 1'b1;
                bank_wr_o[b].addr = single_addr;
                bank_wr_o[b].data = weight_data_i;
            end else if (batch_we_i) begin
                bank_wr_o[b].we   = 1'b1;
                bank_wr_o[b].addr = batch_addr;
                bank_wr_o[b].data = batch_data_i[b];
            end
        end
    end

endmodule

`default_nettype wire
